/* rtl/cam_link_pkg.sv */
`default_nettype none

package cam_link_pkg;

  // link geometry
  // four data lanes, so one nibble per dclk rising edge
  localparam int LANES             = 4;
  localparam int NIBBLES_PER_PIXEL = 2;
  localparam int PIXEL_W           = LANES * NIBBLES_PER_PIXEL;

  // pin synchronizer depth, same for every link pin
  localparam int SYNC_STAGES = 2;

  // memory chunk packing
  // pixel 0 sits in the low byte of a chunk
  localparam int CHUNK_W          = 128;
  localparam int PIXELS_PER_CHUNK = CHUNK_W / PIXEL_W;
  localparam int SLOT_W           = $clog2(PIXELS_PER_CHUNK);

  // frame framing, 160 x 90 pixels
  localparam int FRAME_PIXELS = 14400;
  localparam int FRAME_CNT_W  = $clog2(FRAME_PIXELS);

  // final-pixel events per group tick and the group counter range
  localparam int FRAME_GROUP = 25;
  localparam int PRESCALE_W  = $clog2(FRAME_GROUP);
  localparam int GROUP_MAX   = 1_000_000;
  localparam int GROUP_W     = 20;

  // receiver FSM
  // idle while chip select is high, then alternates high and low nibble
  typedef enum logic [1:0] {
    RX_IDLE = 2'd0,
    RX_HIGH = 2'd1,
    RX_LOW  = 2'd2
  } rx_state_t;

endpackage

`default_nettype wire

/* rtl/qspi_pixel_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module qspi_pixel_rx import cam_link_pkg::*; (
  input  wire                clk_camera,
  input  wire                sys_rst_camera,
  // link pins, asynchronous to clk_camera
  input  wire  [LANES-1:0]   cipo_i,
  input  wire                dclk_i,
  input  wire                cs_n_i,
  input  wire                tlast_i,
  // one-cycle pixel strobe
  output logic               pix_valid_o,
  output logic [PIXEL_W-1:0] pix_data_o,
  output logic               pix_final_o
);

  // synchronizer chains, oldest stage is the synchronized value
  logic [SYNC_STAGES-1:0] dclk_sync;
  logic [SYNC_STAGES-1:0] cs_n_sync;
  logic [SYNC_STAGES-1:0] tlast_sync;
  logic [LANES-1:0]       cipo_sync [SYNC_STAGES];

  // edge detect stage
  logic             dclk_d;
  logic             rise_q;
  logic             cs_n_q;
  logic [LANES-1:0] nib_q;
  logic             last_q;

  // assembly
  rx_state_t        state_q;
  logic [LANES-1:0] hi_nib_q;

  // control pins settle to their idle levels under reset
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      dclk_sync <= '0;
      cs_n_sync <= '1;
    end else begin
      dclk_sync <= {dclk_sync[SYNC_STAGES-2:0], dclk_i};
      cs_n_sync <= {cs_n_sync[SYNC_STAGES-2:0], cs_n_i};
    end
  end

  // data pins take the same number of stages as dclk
  always_ff @(posedge clk_camera) begin
    tlast_sync   <= {tlast_sync[SYNC_STAGES-2:0], tlast_i};
    cipo_sync[0] <= cipo_i;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      cipo_sync[i] <= cipo_sync[i-1];
    end
  end

  // registered rise of the synchronized dclk
  // nibble, final flag and chip select are sampled alongside it
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      dclk_d <= 1'b0;
      rise_q <= 1'b0;
      cs_n_q <= 1'b1;
    end else begin
      dclk_d <= dclk_sync[SYNC_STAGES-1];
      rise_q <= dclk_sync[SYNC_STAGES-1] & ~dclk_d;
      cs_n_q <= cs_n_sync[SYNC_STAGES-1];
    end
  end

  always_ff @(posedge clk_camera) begin
    nib_q  <= cipo_sync[SYNC_STAGES-1];
    last_q <= tlast_sync[SYNC_STAGES-1];
  end

  // nibble pair FSM, upper nibble first
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      state_q     <= RX_IDLE;
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      if (cs_n_q) begin
        // deselect drops any half pixel
        state_q <= RX_IDLE;
      end else begin
        case (state_q)
          RX_IDLE, RX_HIGH: begin
            state_q <= rise_q ? RX_LOW : RX_HIGH;
          end
          RX_LOW: begin
            if (rise_q) begin
              pix_valid_o <= 1'b1;
              state_q     <= RX_HIGH;
            end
          end
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  // payload follows the FSM decisions, no reset needed
  always_ff @(posedge clk_camera) begin
    if (rise_q && !cs_n_q) begin
      if (state_q == RX_LOW) begin
        pix_data_o  <= {hi_nib_q, nib_q};
        pix_final_o <= last_q;
      end else begin
        hi_nib_q <= nib_q;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/chunk_stacker.sv */
`timescale 1ns/1ps
`default_nettype none

module chunk_stacker import cam_link_pkg::*; (
  input  wire                clk_camera,
  input  wire                sys_rst_camera,
  // pixel stream from the receiver
  input  wire                pix_valid_i,
  input  wire  [PIXEL_W-1:0] pix_data_i,
  input  wire                pix_final_i,
  // chunk strobe toward memory, no back-pressure
  output logic               chunk_valid_o,
  output logic [CHUNK_W-1:0] chunk_data_o,
  output logic               chunk_last_o
);

  // byte slot of the next pixel
  logic [SLOT_W-1:0]  slot_q;
  // accumulator, bytes above the slot may be stale
  logic [CHUNK_W-1:0] acc_q;
  logic [CHUNK_W-1:0] acc_next;
  // accumulator with the stale bytes cleared
  logic [CHUNK_W-1:0] chunk_next;
  logic               chunk_done;

  // drop the new pixel into its byte
  always_comb begin
    acc_next = acc_q;
    acc_next[slot_q*PIXEL_W +: PIXEL_W] = pix_data_i;
  end

  // keep bytes 0 to slot, zero the rest
  // an early chunk leaves with zero padding this way
  always_comb begin
    for (int k = 0; k < PIXELS_PER_CHUNK; k++) begin
      if (k <= int'(slot_q)) begin
        chunk_next[k*PIXEL_W +: PIXEL_W] = acc_next[k*PIXEL_W +: PIXEL_W];
      end else begin
        chunk_next[k*PIXEL_W +: PIXEL_W] = '0;
      end
    end
  end

  // full chunk or final pixel closes it
  assign chunk_done = pix_valid_i &&
                      ((slot_q == SLOT_W'(PIXELS_PER_CHUNK - 1)) || pix_final_i);

  // slot counter and strobe
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      slot_q        <= '0;
      chunk_valid_o <= 1'b0;
      chunk_last_o  <= 1'b0;
    end else begin
      chunk_valid_o <= chunk_done;
      if (chunk_done) begin
        // next chunk starts at byte 0
        slot_q       <= '0;
        chunk_last_o <= pix_final_i;
      end else if (pix_valid_i) begin
        slot_q <= slot_q + 1'b1;
      end
    end
  end

  // accumulator and output data
  // data holds until the next chunk
  always_ff @(posedge clk_camera) begin
    if (pix_valid_i) begin
      acc_q <= acc_next;
    end
    if (chunk_done) begin
      chunk_data_o <= chunk_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/link_status.sv */
`timescale 1ns/1ps
`default_nettype none

module link_status import cam_link_pkg::*; (
  input  wire                clk_camera,
  input  wire                sys_rst_camera,
  // pixel stream from the receiver
  input  wire                pix_valid_i,
  input  wire                pix_final_i,
  // sticky framing error and frame group count
  output logic               frame_error_o,
  output logic [GROUP_W-1:0] group_count_o
);

  // position of the current pixel within its frame
  logic [FRAME_CNT_W-1:0] pix_cnt_q;
  logic                   is_last_pix;
  logic                   mismatch;

  // final-pixel prescaler
  logic [PRESCALE_W-1:0]  pre_q;
  logic                   final_evt;
  logic                   group_tick;

  // the count says this pixel ends a frame
  assign is_last_pix = (pix_cnt_q == FRAME_CNT_W'(FRAME_PIXELS - 1));

  // count and flag must agree on every pixel
  assign mismatch = pix_valid_i && (is_last_pix != pix_final_i);

  assign final_evt  = pix_valid_i && pix_final_i;
  assign group_tick = final_evt && (pre_q == PRESCALE_W'(FRAME_GROUP - 1));

  // pixel counter, modulo the frame size
  // a final pixel also restarts it so one bad frame does not skew the next
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pix_cnt_q <= '0;
    end else if (pix_valid_i) begin
      if (pix_final_i || is_last_pix) begin
        pix_cnt_q <= '0;
      end else begin
        pix_cnt_q <= pix_cnt_q + 1'b1;
      end
    end
  end

  // error flag stays set until reset
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      frame_error_o <= 1'b0;
    end else if (mismatch) begin
      frame_error_o <= 1'b1;
    end
  end

  // divide final-pixel events by the group size
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pre_q <= '0;
    end else if (final_evt) begin
      if (group_tick) begin
        pre_q <= '0;
      end else begin
        pre_q <= pre_q + 1'b1;
      end
    end
  end

  // group counter, wraps to zero at GROUP_MAX
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      group_count_o <= '0;
    end else if (group_tick) begin
      if (group_count_o == GROUP_W'(GROUP_MAX - 1)) begin
        group_count_o <= '0;
      end else begin
        group_count_o <= group_count_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/cam_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_link_top import cam_link_pkg::*; (
  input  wire                clk_camera,
  input  wire                sys_rst_camera,
  // camera link pins
  input  wire  [LANES-1:0]   cipo_i,
  input  wire                dclk_i,
  input  wire                cs_n_i,
  input  wire                tlast_i,
  // chunk strobe toward memory
  output logic               chunk_valid_o,
  output logic [CHUNK_W-1:0] chunk_data_o,
  output logic               chunk_last_o,
  // link status
  output logic               frame_error_o,
  output logic [GROUP_W-1:0] group_count_o
);

  // pixel stream shared by the stacker and the status block
  logic               pix_valid;
  logic [PIXEL_W-1:0] pix_data;
  logic               pix_final;

  // decode, pins to pixels
  qspi_pixel_rx u_rx (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .cipo_i         (cipo_i),
    .dclk_i         (dclk_i),
    .cs_n_i         (cs_n_i),
    .tlast_i        (tlast_i),
    .pix_valid_o    (pix_valid),
    .pix_data_o     (pix_data),
    .pix_final_o    (pix_final)
  );

  // execute, pixels to 128-bit chunks
  chunk_stacker u_stacker (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .pix_valid_i    (pix_valid),
    .pix_data_i     (pix_data),
    .pix_final_i    (pix_final),
    .chunk_valid_o  (chunk_valid_o),
    .chunk_data_o   (chunk_data_o),
    .chunk_last_o   (chunk_last_o)
  );

  // result, framing check and group count
  link_status u_status (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .pix_valid_i    (pix_valid),
    .pix_final_i    (pix_final),
    .frame_error_o  (frame_error_o),
    .group_count_o  (group_count_o)
  );

endmodule

`default_nettype wire

/* tb/cam_link_tasks.svh */
`ifndef CAM_LINK_TASKS_SVH
`define CAM_LINK_TASKS_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// next random pixel from the low byte of the generator state
function automatic logic [PIXEL_W-1:0] random_pixel();
  rng_state = xorshift32(rng_state);
  return rng_state[PIXEL_W-1:0];
endfunction

// chip select low starts a burst
task automatic select_link();
  @(negedge clk_camera);
  cs_n_i = 1'b0;
endtask

// chip select high drops any half pixel
task automatic deselect_link();
  @(negedge clk_camera);
  cs_n_i = 1'b1;
endtask

// one link beat
// data changes with the falling dclk and holds past the rise
// dclk low 4 cycles, then high 4 cycles counting the next call
task automatic send_nibble(input logic [LANES-1:0] nib, input bit last);
  @(negedge clk_camera);
  dclk_i  = 1'b0;
  cipo_i  = nib;
  tlast_i = last;
  repeat (4) @(negedge clk_camera);
  dclk_i = 1'b1;
  repeat (3) @(negedge clk_camera);
endtask

// upper nibble first
// tlast rides only with the lower nibble where the receiver latches it
// model is updated before the pins so the expected chunk is queued in time
task automatic send_pixel(input logic [PIXEL_W-1:0] px, input bit last);
  expect_pixel(px, last);
  send_nibble(px[PIXEL_W-1 -: LANES], 1'b0);
  send_nibble(px[LANES-1:0], last);
endtask

// random pixels with tlast only on the last one
task automatic send_frame(input int n_pix);
  for (int i = 0; i < n_pix; i++) begin
    send_pixel(random_pixel(), i == n_pix - 1);
  end
endtask

`endif

/* tb/cam_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_link_tb import cam_link_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  // pixels sent over all tests set the watchdog budget
  localparam int TOTAL_PIXELS    = 32 + 5 + 16 + 25 * 16 + FRAME_PIXELS;
  localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 20 * 3 / 2;
  // polling bound while waiting on the DUT
  localparam int WAIT_LIMIT = 50;

  logic               clk_camera;
  logic               sys_rst_camera;
  logic [LANES-1:0]   cipo_i;
  logic               dclk_i;
  logic               cs_n_i;
  logic               tlast_i;
  logic               chunk_valid_o;
  logic [CHUNK_W-1:0] chunk_data_o;
  logic               chunk_last_o;
  logic               frame_error_o;
  logic [GROUP_W-1:0] group_count_o;

  // reference model state
  logic [PIXEL_W-1:0] pend_q[$];
  logic [CHUNK_W-1:0] exp_data_q[$];
  bit                 exp_last_q[$];
  bit                 idle_window;
  logic [31:0]        rng_state;

  cam_link_top UUT (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .cipo_i         (cipo_i),
    .dclk_i         (dclk_i),
    .cs_n_i         (cs_n_i),
    .tlast_i        (tlast_i),
    .chunk_valid_o  (chunk_valid_o),
    .chunk_data_o   (chunk_data_o),
    .chunk_last_o   (chunk_last_o),
    .frame_error_o  (frame_error_o),
    .group_count_o  (group_count_o)
  );

  initial begin
    clk_camera = 1'b0;
    forever #(CLK_PERIOD / 2) clk_camera = ~clk_camera;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic value_error(input string msg);
    abort_run($sformatf("FAILED at %0t: %s", $time, msg));
  endtask

  // pixel k of a chunk goes to byte k and an early close pads with zeros
  task automatic expect_pixel(input logic [PIXEL_W-1:0] px, input bit last);
    logic [CHUNK_W-1:0] chunk;
    pend_q.push_back(px);
    if (pend_q.size() == PIXELS_PER_CHUNK || last) begin
      chunk = '0;
      for (int k = 0; k < pend_q.size(); k++) begin
        chunk[k*PIXEL_W +: PIXEL_W] = pend_q[k];
      end
      exp_data_q.push_back(chunk);
      exp_last_q.push_back(last);
      pend_q.delete();
    end
  endtask

  `include "cam_link_tasks.svh"

  // reset with the link idle for RESET_CYCLES rising edges
  task automatic apply_reset();
    @(negedge clk_camera);
    sys_rst_camera = 1'b1;
    cs_n_i         = 1'b1;
    dclk_i         = 1'b0;
    tlast_i        = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_camera);
    sys_rst_camera = 1'b0;
  endtask

  // poll until every expected chunk has come out
  task automatic wait_drained(input string label);
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(negedge clk_camera);
      waited++;
    end
    assert (exp_data_q.size() == 0)
      else abort_run($sformatf("%s: an expected chunk never arrived", label));
  endtask

  // bounded poll since status settles 5 cycles after the pin edge
  task automatic wait_status(input bit err, input int group, input string label);
    int waited;
    waited = 0;
    while ((frame_error_o !== err || group_count_o !== GROUP_W'(group)) &&
           waited < WAIT_LIMIT) begin
      @(negedge clk_camera);
      waited++;
    end
    assert (frame_error_o === err && group_count_o === GROUP_W'(group))
      else value_error($sformatf(
        "%s: frame_error_o %0b group_count_o %0d, expected %0b and %0d",
        label, frame_error_o, group_count_o, err, group));
  endtask

  // chunk monitor samples at the falling edge where outputs are stable
  always @(negedge clk_camera) begin
    if (!sys_rst_camera && chunk_valid_o) begin
      assert (exp_data_q.size() != 0)
        else abort_run("a chunk came out that no sent pixel accounts for");
      if (exp_data_q.size() != 0) begin
        assert (chunk_data_o === exp_data_q[0])
          else value_error($sformatf("chunk data %h, expected %h",
                                     chunk_data_o, exp_data_q[0]));
        assert (chunk_last_o === exp_last_q[0])
          else value_error($sformatf("chunk_last_o %0b, expected %0b",
                                     chunk_last_o, exp_last_q[0]));
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
      end
    end
  end

  // quiet outputs from reset until the first pixel
  always @(negedge clk_camera) begin
    if (idle_window && !sys_rst_camera) begin
      assert (chunk_valid_o === 1'b0 && chunk_last_o === 1'b0 &&
              frame_error_o === 1'b0 && group_count_o === '0)
        else value_error("outputs not at their reset values before the first pixel");
    end
  end

  strobe_one_cycle: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
    chunk_valid_o |=> !chunk_valid_o)
    else value_error("chunk_valid_o high for more than one cycle");

  error_sticky: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
    frame_error_o |=> frame_error_o)
    else value_error("frame_error_o dropped without a reset");

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_camera);
    abort_run("timeout: the tests did not finish within the cycle budget");
  end

  initial begin
    sys_rst_camera = 1'b1;
    cipo_i         = '0;
    dclk_i         = 1'b0;
    cs_n_i         = 1'b1;
    tlast_i        = 1'b0;
    idle_window    = 1'b1;
    rng_state      = 32'd14968;
    repeat (RESET_CYCLES) @(negedge clk_camera);
    sys_rst_camera = 1'b0;
    repeat (10) @(negedge clk_camera);

    // two full chunks without tlast
    select_link();
    send_pixel(random_pixel(), 1'b0);
    idle_window = 1'b0;
    repeat (31) send_pixel(random_pixel(), 1'b0);
    wait_drained("32 pixels");

    // early chunk closed by tlast on the fifth pixel
    repeat (4) send_pixel(random_pixel(), 1'b0);
    send_pixel(random_pixel(), 1'b1);
    wait_drained("five pixels");

    // stray nibble dropped by a chip select rise
    send_nibble(4'hA, 1'b0);
    deselect_link();
    repeat (6) @(negedge clk_camera);
    select_link();
    repeat (16) send_pixel(random_pixel(), 1'b0);
    wait_drained("stray nibble");

    // short frames set the error and 25 of them make one group
    apply_reset();
    wait_status(1'b0, 0, "after reset");
    select_link();
    send_frame(16);
    wait_status(1'b1, 0, "first short frame");
    repeat (24) send_frame(16);
    wait_drained("short frames");
    wait_status(1'b1, 1, "25 short frames");
    apply_reset();
    wait_status(1'b0, 0, "reset after short frames");

    // one correct full frame
    select_link();
    send_frame(FRAME_PIXELS);
    wait_drained("full frame");
    wait_status(1'b0, 0, "full frame");

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tb
rtl/cam_link_pkg.sv
rtl/qspi_pixel_rx.sv
rtl/chunk_stacker.sv
rtl/link_status.sv
rtl/cam_link_top.sv
tb/cam_link_tb.sv

/* Bender.yml */
package:
  name: cam_link

sources:
  - rtl/cam_link_pkg.sv
  - rtl/qspi_pixel_rx.sv
  - rtl/chunk_stacker.sv
  - rtl/link_status.sv
  - rtl/cam_link_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cam_link_tb.sv
